// File: expr_eval.f
logic/expr_token_pkg.sv
logic/expr_ctrl_pkg.sv
logic/expr_alu.sv
logic/token_capture.sv
logic/stack_evaluator.sv
logic/expr_eval_top.sv
verif/expr_eval_assertions.sv
verif/expr_eval_tb.sv

// File: Bender.yml
package:
  name: expr_eval

sources:
  - files:
      - logic/expr_token_pkg.sv
      - logic/expr_ctrl_pkg.sv
      - logic/expr_alu.sv
      - logic/token_capture.sv
      - logic/stack_evaluator.sv
      - logic/expr_eval_top.sv
  - target: simulation
    files:
      - verif/expr_eval_assertions.sv
      - verif/expr_eval_tb.sv

// File: verif/expr_eval_tb.sv
`timescale 1ns/10ps

module expr_eval_tb;

	localparam int MAX_TOKENS     = 19;
	localparam int CLK_PERIOD     = 8;
	localparam int SEED           = 83469;
	// about 50 frames of at most ~250 cycles each plus margin
	localparam int TIMEOUT_CYCLES = 20000;

	logic                     clk_2;
	logic                     rst_n;
	logic                     in_valid;
	expr_token_pkg::tok_val_t tok_in;
	logic                     op_flag;
	logic                     mode;
	logic                     out_valid;
	expr_token_pkg::result_t  result;

	// frame being built in written order
	expr_token_pkg::tok_val_t tok_q[$];
	logic                     opf_q[$];

	int pass_cnt = 0;
	int fail_cnt = 0;
	int cycles   = 0;

	expr_eval_top #(
		.MAX_TOKENS (MAX_TOKENS)
	) DUT (
		.clk_2     (clk_2),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.tok_in    (tok_in),
		.op_flag   (op_flag),
		.mode      (mode),
		.out_valid (out_valid),
		.result    (result)
	);

	initial clk_2 = 1'b0;
	always #(CLK_PERIOD / 2) clk_2 = ~clk_2;

	// run limit
	always @(posedge clk_2) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ==========================================================
	// compare tasks
	// ==========================================================
	task automatic check_result(input string name, input expr_token_pkg::result_t exp,
		input expr_token_pkg::result_t act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s: expected %0d, got %0d", $time, name, exp, act);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[FAIL] t=%0t %s: expected %b, got %b", $time, name, exp, act);
			fail_cnt++;
		end else begin
			pass_cnt++;
		end
	endtask

	task automatic close_test(input string name, input int fails_before);
		if (fail_cnt == fails_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d mismatches", name, fail_cnt - fails_before);
		end
	endtask

	// ==========================================================
	// reference model
	// ==========================================================
	// a is the operand written first
	function automatic expr_token_pkg::result_t apply_op(input expr_token_pkg::opcode_e op,
		input expr_token_pkg::result_t a, input expr_token_pkg::result_t b);
		expr_token_pkg::result_t s;
		s = a + b;
		case (op)
			expr_token_pkg::OP_ADD: return s;
			expr_token_pkg::OP_SUB: return a - b;
			expr_token_pkg::OP_MUL: return a * b;
			expr_token_pkg::OP_ABS: return (s < 0) ? -s : s;
			expr_token_pkg::OP_TWO: return 2 * (a - b);
			default:                return '0;
		endcase
	endfunction

	function automatic expr_token_pkg::result_t ref_eval(input expr_ctrl_pkg::notation_e md);
		expr_token_pkg::result_t v[$];
		logic                    o[$];
		int                      i;
		foreach (tok_q[k]) begin
			v.push_back(expr_token_pkg::result_t'(tok_q[k]));
			o.push_back(opf_q[k]);
		end
		while (v.size() > 1) begin
			if (md == expr_ctrl_pkg::PREFIX) begin
				// rightmost operator with its operands following it
				i = v.size() - 1;
				while (!o[i]) i--;
				v[i] = apply_op(expr_token_pkg::opcode_e'(v[i][2:0]), v[i+1], v[i+2]);
				o[i] = 1'b0;
				v.delete(i + 2);
				o.delete(i + 2);
				v.delete(i + 1);
				o.delete(i + 1);
			end else begin
				// leftmost operator with its operands before it
				i = 2;
				while (!o[i]) i++;
				v[i-2] = apply_op(expr_token_pkg::opcode_e'(v[i][2:0]), v[i-2], v[i-1]);
				v.delete(i);
				o.delete(i);
				v.delete(i - 1);
				o.delete(i - 1);
			end
		end
		return v[0];
	endfunction

	// ==========================================================
	// frame building and driving
	// ==========================================================
	task automatic clear_frame();
		tok_q.delete();
		opf_q.delete();
	endtask

	// front set prepends so a postfix walk builds a mirrored prefix frame
	task automatic add_tok(input logic front, input logic is_op, input int val);
		if (front) begin
			tok_q.push_front(expr_token_pkg::tok_val_t'(val));
			opf_q.push_front(is_op);
		end else begin
			tok_q.push_back(expr_token_pkg::tok_val_t'(val));
			opf_q.push_back(is_op);
		end
	endtask

	// well-formed random frame from a stack depth walk
	task automatic build_random(input expr_ctrl_pkg::notation_e md, input int n_ops);
		int depth;
		int opd_left;
		int op_left;
		logic front;
		depth    = 0;
		opd_left = n_ops + 1;
		op_left  = n_ops;
		front    = (md == expr_ctrl_pkg::PREFIX);
		clear_frame();
		while (opd_left + op_left > 0) begin
			if (depth >= 2 && op_left > 0 && (opd_left == 0 || $urandom_range(1, 0) == 1)) begin
				add_tok(front, 1'b1, $urandom_range(4, 0));
				depth--;
				op_left--;
			end else begin
				add_tok(front, 1'b0, $urandom_range(7, 0));
				depth++;
				opd_left--;
			end
		end
	endtask

	// first n tokens of the queue then junk on the token lines
	task automatic drive_frame(input expr_ctrl_pkg::notation_e md, input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk_2);
			#1;
			in_valid = 1'b1;
			tok_in   = tok_q[i];
			op_flag  = opf_q[i];
			// only the first token's mode counts
			mode     = (i == 0) ? md : !md;
		end
		@(posedge clk_2);
		#1;
		in_valid = 1'b0;
		tok_in   = expr_token_pkg::tok_val_t'($urandom);
		op_flag  = 1'b1;
	endtask

	task automatic wait_result(input expr_token_pkg::result_t exp);
		do begin
			@(posedge clk_2);
			#1;
		end while (!out_valid);
		check_result("result", exp, result);
		// pulse must drop after one cycle
		@(posedge clk_2);
		#1;
		check_flag("out_valid", 1'b0, out_valid);
		check_result("result", '0, result);
		repeat (2) @(posedge clk_2);
	endtask

	task automatic run_frame(input expr_ctrl_pkg::notation_e md);
		expr_token_pkg::result_t exp;
		exp = ref_eval(md);
		drive_frame(md, tok_q.size());
		wait_result(exp);
	endtask

	// ==========================================================
	// tests
	// ==========================================================
	task automatic test_three_tokens(input expr_ctrl_pkg::notation_e md, input string name);
		int f0;
		f0 = fail_cnt;
		for (int c = 0; c < 5; c++) begin
			clear_frame();
			if (md == expr_ctrl_pkg::PREFIX) begin
				add_tok(1'b0, 1'b1, c);
			end
			add_tok(1'b0, 1'b0, 3);
			add_tok(1'b0, 1'b0, 6);
			if (md == expr_ctrl_pkg::POSTFIX) begin
				add_tok(1'b0, 1'b1, c);
			end
			drive_frame(md, tok_q.size());
			wait_result(apply_op(expr_token_pkg::opcode_e'(c), 3, 6));
		end
		close_test(name, f0);
	endtask

	task automatic test_long_frames();
		int f0;
		f0 = fail_cnt;
		// postfix 7 7 * 7 * ... with nine multiplies
		clear_frame();
		add_tok(1'b0, 1'b0, 7);
		for (int i = 0; i < 9; i++) begin
			add_tok(1'b0, 1'b0, 7);
			add_tok(1'b0, 1'b1, expr_token_pkg::OP_MUL);
		end
		run_frame(expr_ctrl_pkg::POSTFIX);
		// prefix with nine SUB and TWO then ten operands going negative
		clear_frame();
		for (int i = 0; i < 9; i++) begin
			add_tok(1'b0, 1'b1, (i % 2) ? expr_token_pkg::OP_TWO : expr_token_pkg::OP_SUB);
		end
		for (int i = 0; i < 10; i++) begin
			add_tok(1'b0, 1'b0, (i * 3) % 8);
		end
		run_frame(expr_ctrl_pkg::PREFIX);
		close_test("long_frames", f0);
	endtask

	task automatic test_undefined_ops();
		int f0;
		f0 = fail_cnt;
		for (int c = 5; c < 8; c++) begin
			// prefix ADD c 3 4 5 where the inner term is zero
			clear_frame();
			add_tok(1'b0, 1'b1, expr_token_pkg::OP_ADD);
			add_tok(1'b0, 1'b1, c);
			add_tok(1'b0, 1'b0, 3);
			add_tok(1'b0, 1'b0, 4);
			add_tok(1'b0, 1'b0, 5);
			run_frame(expr_ctrl_pkg::PREFIX);
			clear_frame();
			add_tok(1'b0, 1'b0, 2);
			add_tok(1'b0, 1'b0, 6);
			add_tok(1'b0, 1'b1, c);
			run_frame(expr_ctrl_pkg::POSTFIX);
		end
		close_test("undefined_ops", f0);
	endtask

	task automatic test_reset_mid_frame();
		int   f0;
		logic seen;
		f0   = fail_cnt;
		seen = 1'b0;
		build_random(expr_ctrl_pkg::POSTFIX, 4);
		// cut the frame after four tokens
		drive_frame(expr_ctrl_pkg::POSTFIX, 4);
		rst_n = 1'b0;
		repeat (2) @(posedge clk_2);
		#1;
		rst_n = 1'b1;
		repeat (40) begin
			@(posedge clk_2);
			#1;
			if (out_valid) begin
				seen = 1'b1;
			end
		end
		check_flag("out_valid", 1'b0, seen);
		check_result("result", '0, result);
		build_random(expr_ctrl_pkg::PREFIX, 5);
		run_frame(expr_ctrl_pkg::PREFIX);
		close_test("reset_mid_frame", f0);
	endtask

	task automatic test_random_frames();
		int                       f0;
		expr_ctrl_pkg::notation_e md;
		f0 = fail_cnt;
		for (int n = 0; n < 30; n++) begin
			md = expr_ctrl_pkg::notation_e'($urandom_range(1, 0));
			build_random(md, $urandom_range(9, 1));
			run_frame(md);
		end
		close_test("random_frames", f0);
	endtask

	// ==========================================================
	// main sequence
	// ==========================================================
	initial begin
		int asrt;
		void'($urandom(SEED));
		rst_n    = 1'b0;
		in_valid = 1'b0;
		tok_in   = '0;
		op_flag  = 1'b0;
		mode     = 1'b0;
		repeat (2) @(posedge clk_2);
		#1;
		rst_n = 1'b1;
		repeat (2) @(posedge clk_2);

		test_three_tokens(expr_ctrl_pkg::POSTFIX, "postfix_ops");
		test_three_tokens(expr_ctrl_pkg::PREFIX, "prefix_ops");
		test_long_frames();
		test_undefined_ops();
		test_reset_mid_frame();
		test_random_frames();

		asrt = DUT.u_assertions.violations;
		$display("checks passed %0d, failed %0d, assertion failures %0d",
			pass_cnt, fail_cnt, asrt);
		if (fail_cnt == 0 && asrt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: verif/expr_eval_assertions.sv
`timescale 1ns/10ps

module expr_eval_assertions (
	input logic                    clk_2,
	input logic                    rst_n,
	input logic                    out_valid,
	input expr_token_pkg::result_t result,
	input logic                    tok_we,
	input logic                    frame_end
);

	// count of failed assertions
	int violations = 0;

	// result pulse lasts one cycle
	single_pulse: assert property (@(posedge clk_2) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else begin
			violations++;
			$error("out_valid high for more than one cycle");
		end

	// no stale value on result between pulses
	result_zero: assert property (@(posedge clk_2) disable iff (!rst_n)
		!out_valid |-> (result == 0))
		else begin
			violations++;
			$error("result nonzero while out_valid low");
		end

	// frame end only in the cycle after the last token write
	no_overlap: assert property (@(posedge clk_2) disable iff (!rst_n)
		frame_end |-> (!tok_we && $past(tok_we)))
		else begin
			violations++;
			$error("frame_end overlaps tok_we or does not follow a token write");
		end

endmodule

bind expr_eval_top expr_eval_assertions u_assertions (
	.clk_2     (clk_2),
	.rst_n     (rst_n),
	.out_valid (out_valid),
	.result    (result),
	.tok_we    (tok_we),
	.frame_end (frame_end)
);

// File: logic/expr_eval_top.sv
`timescale 1ns/10ps

module expr_eval_top #(
	// buffer depth, odd and at least 3
	parameter int MAX_TOKENS = 19
) (
	input  logic                     clk_2,
	input  logic                     rst_n,
	input  logic                     in_valid,
	input  expr_token_pkg::tok_val_t tok_in,
	input  logic                     op_flag,
	input  logic                     mode,
	output logic                     out_valid,
	output expr_token_pkg::result_t  result
);

	// ==========================================================
	// capture to evaluator
	// ==========================================================
	logic                     tok_we;
	expr_token_pkg::tok_val_t tok_value;
	logic                     tok_is_op;
	expr_ctrl_pkg::notation_e frame_mode;
	logic                     frame_end;

	token_capture #(
		.MAX_TOKENS (MAX_TOKENS)
	) u_capture (
		.clk_2      (clk_2),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.tok_in     (tok_in),
		.op_flag    (op_flag),
		.mode       (mode),
		.tok_we     (tok_we),
		.tok_value  (tok_value),
		.tok_is_op  (tok_is_op),
		.frame_mode (frame_mode),
		.frame_end  (frame_end)
	);

	stack_evaluator #(
		.MAX_TOKENS (MAX_TOKENS)
	) u_eval (
		.clk_2      (clk_2),
		.rst_n      (rst_n),
		.tok_we     (tok_we),
		.tok_value  (tok_value),
		.tok_is_op  (tok_is_op),
		.frame_mode (frame_mode),
		.frame_end  (frame_end),
		.out_valid  (out_valid),
		.result     (result)
	);

endmodule

// File: logic/stack_evaluator.sv
`timescale 1ns/10ps

module stack_evaluator #(
	parameter int MAX_TOKENS = 19
) (
	input  logic                       clk_2,
	input  logic                       rst_n,
	input  logic                       tok_we,
	input  expr_token_pkg::tok_val_t   tok_value,
	input  logic                       tok_is_op,
	input  expr_ctrl_pkg::notation_e   frame_mode,
	input  logic                       frame_end,
	output logic                       out_valid,
	output expr_token_pkg::result_t    result
);

	// MAX_TOKENS is odd, so this width also holds the full count
	localparam int IDX_W = $clog2(MAX_TOKENS);

	expr_ctrl_pkg::eval_state_e state, state_nxt;

	// token buffer and operator bitmap
	expr_token_pkg::result_t buf_q [0:MAX_TOKENS-1];
	logic [MAX_TOKENS-1:0]   op_map;
	// write pointer while reading, scan pointer afterwards
	logic [IDX_W-1:0]        ptr;
	// operators not yet applied
	logic [IDX_W-1:0]        op_cnt;

	// operand slots around the operator and writeback slot
	logic [IDX_W-1:0]        idx_a;
	logic [IDX_W-1:0]        idx_b;
	logic [IDX_W-1:0]        dst;
	logic [IDX_W-1:0]        ptr_restart;
	logic                    op_found;
	logic                    last_op;

	// alu operands and output
	expr_token_pkg::opcode_e op_q;
	expr_token_pkg::result_t a_q;
	expr_token_pkg::result_t b_q;
	expr_token_pkg::result_t alu_y;
	expr_token_pkg::result_t calc_q;

	assign op_found = (state == expr_ctrl_pkg::SCAN) && op_map[ptr];
	assign last_op  = (op_cnt == IDX_W'(1));

	// postfix: operands sit before the operator, result lands on a
	// prefix: operands follow it, result replaces the operator
	always_comb begin
		if (frame_mode == expr_ctrl_pkg::POSTFIX) begin
			idx_a       = ptr - IDX_W'(2);
			idx_b       = ptr - IDX_W'(1);
			dst         = ptr - IDX_W'(2);
			// nothing before the result can be an operator
			ptr_restart = (ptr == IDX_W'(2)) ? IDX_W'(2) : ptr - IDX_W'(1);
		end else begin
			idx_a       = ptr + IDX_W'(1);
			idx_b       = ptr + IDX_W'(2);
			dst         = ptr;
			ptr_restart = ptr - IDX_W'(1);
		end
	end

	// ==========================================================
	// fsm
	// ==========================================================
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			state <= expr_ctrl_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	always_comb begin
		case (state)
			expr_ctrl_pkg::IDLE: state_nxt = expr_ctrl_pkg::READ;
			expr_ctrl_pkg::READ: begin
				state_nxt = expr_ctrl_pkg::READ;
				// a frame without operators has nothing to evaluate
				if (frame_end) begin
					state_nxt = (op_cnt == '0) ? expr_ctrl_pkg::IDLE : expr_ctrl_pkg::SCAN;
				end
			end
			expr_ctrl_pkg::SCAN:
				state_nxt = op_found ? expr_ctrl_pkg::CALC : expr_ctrl_pkg::SCAN;
			expr_ctrl_pkg::CALC: state_nxt = expr_ctrl_pkg::WRITEBACK;
			expr_ctrl_pkg::WRITEBACK:
				state_nxt = last_op ? expr_ctrl_pkg::IDLE : expr_ctrl_pkg::SCAN;
			default: state_nxt = expr_ctrl_pkg::IDLE;
		endcase
	end

	// ==========================================================
	// pointer and operator count
	// ==========================================================
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			ptr    <= '0;
			op_cnt <= '0;
		end else if (tok_we) begin
			ptr <= ptr + IDX_W'(1);
			if (tok_is_op) begin
				op_cnt <= op_cnt + IDX_W'(1);
			end
		end else if (frame_end) begin
			// postfix scans up from slot 2, prefix down from the end
			ptr <= (frame_mode == expr_ctrl_pkg::POSTFIX) ? IDX_W'(2) : ptr - IDX_W'(1);
		end else if (state == expr_ctrl_pkg::SCAN && !op_found) begin
			ptr <= (frame_mode == expr_ctrl_pkg::POSTFIX) ? ptr + IDX_W'(1) : ptr - IDX_W'(1);
		end else if (state == expr_ctrl_pkg::WRITEBACK) begin
			ptr    <= ptr_restart;
			op_cnt <= op_cnt - IDX_W'(1);
		end else if (state == expr_ctrl_pkg::IDLE) begin
			ptr <= '0;
		end
	end

	// operator bitmap, compacted together with the buffer
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			op_map <= '0;
		end else if (tok_we) begin
			op_map[ptr] <= tok_is_op;
		end else if (state == expr_ctrl_pkg::WRITEBACK) begin
			op_map[MAX_TOKENS-1] <= 1'b0;
			op_map[MAX_TOKENS-2] <= 1'b0;
			for (int i = 0; i < MAX_TOKENS - 2; i++) begin
				if (IDX_W'(i) > dst) begin
					op_map[i] <= op_map[i+2];
				end
			end
			op_map[dst] <= 1'b0;
		end else if (state == expr_ctrl_pkg::IDLE) begin
			op_map <= '0;
		end
	end

	// ==========================================================
	// token buffer
	// ==========================================================
	always_ff @(posedge clk_2) begin
		if (tok_we) begin
			buf_q[ptr] <= expr_token_pkg::result_t'(tok_value);
		end else if (state == expr_ctrl_pkg::WRITEBACK) begin
			// tail slots empty after the gap closes
			buf_q[MAX_TOKENS-1] <= '0;
			buf_q[MAX_TOKENS-2] <= '0;
			for (int i = 0; i < MAX_TOKENS - 2; i++) begin
				if (IDX_W'(i) > dst) begin
					buf_q[i] <= buf_q[i+2];
				end
			end
			buf_q[dst] <= calc_q;
		end else if (state == expr_ctrl_pkg::IDLE) begin
			for (int i = 0; i < MAX_TOKENS; i++) begin
				buf_q[i] <= '0;
			end
		end
	end

	// operator and operands latched when the scan hits
	always_ff @(posedge clk_2) begin
		if (op_found) begin
			op_q <= expr_token_pkg::opcode_e'(buf_q[ptr][2:0]);
			a_q  <= buf_q[idx_a];
			b_q  <= buf_q[idx_b];
		end
		if (state == expr_ctrl_pkg::CALC) begin
			calc_q <= alu_y;
		end
	end

	expr_alu u_alu (
		.op (op_q),
		.a  (a_q),
		.b  (b_q),
		.y  (alu_y)
	);

	// ==========================================================
	// output
	// ==========================================================
	// one-cycle pulse after the last writeback, zero otherwise
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			result    <= '0;
		end else if (state == expr_ctrl_pkg::WRITEBACK && last_op) begin
			out_valid <= 1'b1;
			result    <= calc_q;
		end else begin
			out_valid <= 1'b0;
			result    <= '0;
		end
	end

endmodule

// File: logic/token_capture.sv
`timescale 1ns/10ps

module token_capture #(
	parameter int MAX_TOKENS = 19
) (
	input  logic                       clk_2,
	input  logic                       rst_n,
	input  logic                       in_valid,
	input  expr_token_pkg::tok_val_t   tok_in,
	input  logic                       op_flag,
	input  logic                       mode,
	output logic                       tok_we,
	output expr_token_pkg::tok_val_t   tok_value,
	output logic                       tok_is_op,
	output expr_ctrl_pkg::notation_e   frame_mode,
	output logic                       frame_end
);

	// enough bits to count up to MAX_TOKENS
	localparam int CNT_W = $clog2(MAX_TOKENS + 1);

	// delayed in_valid for edge detection
	logic             in_valid_r;
	// tokens taken so far in this frame
	logic [CNT_W-1:0] tok_cnt;
	// token is taken this cycle
	logic             accept;

	// tokens beyond the buffer depth are dropped
	// so a long frame cannot overrun the evaluator
	assign accept = in_valid && (tok_cnt < CNT_W'(MAX_TOKENS));

	// ==========================================================
	// edge tracking
	// ==========================================================
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			in_valid_r <= 1'b0;
			tok_cnt    <= '0;
		end else begin
			in_valid_r <= in_valid;
			// restart count between frames
			if (!in_valid) begin
				tok_cnt <= '0;
			end else if (accept) begin
				tok_cnt <= tok_cnt + CNT_W'(1);
			end
		end
	end

	// ==========================================================
	// filtered token stage
	// ==========================================================
	// zero outside valid cycles, no unknowns reach the buffer
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			tok_we    <= 1'b0;
			tok_value <= '0;
			tok_is_op <= 1'b0;
		end else begin
			tok_we <= accept;
			if (accept) begin
				tok_value <= tok_in;
				tok_is_op <= op_flag;
			end else begin
				tok_value <= '0;
				tok_is_op <= 1'b0;
			end
		end
	end

	// mode taken on rising edge of in_valid, held to next frame
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			frame_mode <= expr_ctrl_pkg::PREFIX;
		end else if (in_valid && !in_valid_r) begin
			frame_mode <= expr_ctrl_pkg::notation_e'(mode);
		end
	end

	// falling edge of in_valid
	// lands one cycle after the last tok_we
	always_ff @(posedge clk_2 or negedge rst_n) begin
		if (!rst_n) begin
			frame_end <= 1'b0;
		end else begin
			frame_end <= !in_valid && in_valid_r;
		end
	end

endmodule

// File: logic/expr_alu.sv
`timescale 1ns/10ps

module expr_alu (
	input  expr_token_pkg::opcode_e op,
	input  expr_token_pkg::result_t a,
	input  expr_token_pkg::result_t b,
	output expr_token_pkg::result_t y
);

	// shared by add / abs and sub / two
	expr_token_pkg::result_t sum;
	expr_token_pkg::result_t diff;

	assign sum  = a + b;
	assign diff = a - b;

	// a is the operand written first, b the second
	always_comb begin
		case (op)
			expr_token_pkg::OP_ADD: y = sum;
			expr_token_pkg::OP_SUB: y = diff;
			// signed product, upper half discarded
			expr_token_pkg::OP_MUL: y = a * b;
			// negate only when the sum went below zero
			expr_token_pkg::OP_ABS: y = (sum < 0) ? -sum : sum;
			// arithmetic shift keeps the sign
			expr_token_pkg::OP_TWO: y = diff <<< 1;
			// codes 5..7
			default:                y = '0;
		endcase
	end

endmodule

// File: logic/expr_ctrl_pkg.sv
// ==========================================================
// control types
// ==========================================================

package expr_ctrl_pkg;

	// notation, sampled from mode on the first token
	typedef enum logic {
		PREFIX  = 1'b0,
		POSTFIX = 1'b1
	} notation_e;

	// evaluator fsm, one-hot
	typedef enum logic [4:0] {
		// clear buffer, one cycle
		IDLE      = 5'b00001,
		// fill buffer until frame end
		READ      = 5'b00010,
		// walk pointer to next operator
		SCAN      = 5'b00100,
		// latch alu output
		CALC      = 5'b01000,
		// store value and compact buffer
		WRITEBACK = 5'b10000
	} eval_state_e;

endpackage

// File: logic/expr_token_pkg.sv
// ==========================================================
// token level types
// ==========================================================
// shared by capture stage, evaluator, alu and testbench

package expr_token_pkg;

	// raw 3-bit token payload
	// operand value 0..7, or opcode when op_flag is set
	typedef logic [2:0] tok_val_t;

	// operator codes as carried on tok_in
	// codes 5..7 are not named and evaluate to zero
	typedef enum logic [2:0] {
		// a + b
		OP_ADD = 3'd0,
		// a - b
		OP_SUB = 3'd1,
		// a * b, low 32 bits
		OP_MUL = 3'd2,
		// |a + b|
		OP_ABS = 3'd3,
		// 2 * (a - b)
		OP_TWO = 3'd4
	} opcode_e;

	// signed arithmetic word
	// buffer slots, alu operands and the final result
	// all math wraps at 32 bits
	typedef logic signed [31:0] result_t;

endpackage
